// File: Makefile
# Verilator flow for the image capture subsystem.

VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= img_top_tb
RTL_TOP    ?= img_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)
SOURCES = $(wildcard src/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "No verdict found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+test
src/img_pkg.sv
src/pix_wr_if.sv
src/mem_rd_if.sv
src/img_sensor_rx.sv
src/img_frame_ram.sv
src/img_readout.sv
src/img_controller.sv
src/img_top.sv
test/img_top_tb.sv

// File: src/img_controller.sv
`timescale 1ns/1ps
`default_nettype none

module img_controller import img_pkg::*; #(
    parameter int IMG_W_MAX = 16,
    parameter int IMG_H_MAX = 8
) (
    input  logic                               ice_img_clk16mhz,
    input  logic                               arst_n,
    input  logic                               cmd_valid,
    input  cmd_op_t                            cmd_op,
    input  logic                               cmd_block,
    output logic                               cmd_ready,
    input  pixel_t                             img_d,
    input  logic                               img_fv,
    input  logic                               img_lv,
    output logic                               capture_done,
    output logic [$clog2(IMG_W_MAX + 1)-1:0]   img_width,
    output logic [$clog2(IMG_H_MAX + 1)-1:0]   img_height,
    output stat_cnt_t                          highlight_count,
    output stat_cnt_t                          shadow_count,
    input  logic                               pix_ready,
    output logic                               pix_valid,
    output pixel_t                             pix_data,
    output logic                               pix_last
);
    localparam int W_W = $clog2(IMG_W_MAX + 1);
    localparam int H_W = $clog2(IMG_H_MAX + 1);

    ctrl_state_t    state;
    ctrl_state_t    state_nxt;
    logic           cur_block;
    logic [W_W-1:0] blk_width [2];  // Size last captured into each block.
    logic [H_W-1:0] blk_height [2];
    logic           accept;
    logic           frame_start;
    logic           frame_end;
    logic           ro_done;

    pix_wr_if #(.IMG_W_MAX(IMG_W_MAX), .IMG_H_MAX(IMG_H_MAX)) pix_wr ();
    mem_rd_if #(.IMG_W_MAX(IMG_W_MAX), .IMG_H_MAX(IMG_H_MAX)) mem_rd ();

    assign accept = cmd_valid && cmd_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            CTRL_IDLE:    if (accept) state_nxt = (cmd_op == OP_CAPTURE) ? CTRL_ARM : CTRL_READOUT;
            CTRL_ARM:     if (frame_start) state_nxt = CTRL_CAPTURE;
            CTRL_CAPTURE: if (frame_end) state_nxt = CTRL_IDLE;
            CTRL_READOUT: if (ro_done) state_nxt = CTRL_IDLE;
            default:      state_nxt = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge ice_img_clk16mhz or negedge arst_n) begin
        if (!arst_n) begin
            state         <= CTRL_IDLE;
            cmd_ready     <= 1'b0;
            capture_done  <= 1'b0;
            cur_block     <= 1'b0;
            blk_width[0]  <= '0;
            blk_width[1]  <= '0;
            blk_height[0] <= '0;
            blk_height[1] <= '0;
        end else begin
            state        <= state_nxt;
            cmd_ready    <= (state_nxt == CTRL_IDLE);
            capture_done <= (state == CTRL_CAPTURE) && frame_end;
            if (accept) cur_block <= cmd_block;
            // Receiver size is final by the done pulse.
            if (capture_done) begin
                blk_width[cur_block]  <= img_width;
                blk_height[cur_block] <= img_height;
            end
        end
    end

    img_sensor_rx #(.IMG_W_MAX(IMG_W_MAX), .IMG_H_MAX(IMG_H_MAX)) i_img_sensor_rx (
        .ice_img_clk16mhz (ice_img_clk16mhz),
        .arst_n           (arst_n),
        .start            (accept && cmd_op == OP_CAPTURE),
        .block            (cur_block),
        .img_d            (img_d),
        .img_fv           (img_fv),
        .img_lv           (img_lv),
        .frame_start      (frame_start),
        .frame_end        (frame_end),
        .width            (img_width),
        .height           (img_height),
        .highlight_count  (highlight_count),
        .shadow_count     (shadow_count),
        .wr               (pix_wr.src)
    );

    img_frame_ram #(.IMG_W_MAX(IMG_W_MAX), .IMG_H_MAX(IMG_H_MAX)) i_img_frame_ram (
        .ice_img_clk16mhz (ice_img_clk16mhz),
        .wr               (pix_wr.dst),
        .rd               (mem_rd.dst)
    );

    img_readout #(.IMG_W_MAX(IMG_W_MAX), .IMG_H_MAX(IMG_H_MAX)) i_img_readout (
        .ice_img_clk16mhz (ice_img_clk16mhz),
        .arst_n           (arst_n),
        .start            (accept && cmd_op == OP_READOUT),
        .block            (cur_block),
        .width            (blk_width[cur_block]),
        .height           (blk_height[cur_block]),
        .pix_ready        (pix_ready),
        .done             (ro_done),
        .pix_valid        (pix_valid),
        .pix_data         (pix_data),
        .pix_last         (pix_last),
        .rd               (mem_rd.src)
    );

    // Stream and buffer writes are quiet whenever a new command is taken.
    cmd_only_in_idle: assert property (@(posedge ice_img_clk16mhz) disable iff (!arst_n)
        accept |-> !pix_valid && !pix_wr.wr_en)
        else $error("Command accepted while busy.");

endmodule

`default_nettype wire

// File: src/img_frame_ram.sv
`timescale 1ns/1ps
`default_nettype none

module img_frame_ram import img_pkg::*; #(
    parameter int IMG_W_MAX = 16,
    parameter int IMG_H_MAX = 8
) (
    input logic   ice_img_clk16mhz,
    pix_wr_if.dst wr,
    mem_rd_if.dst rd
);
    localparam int ADDR_W = $clog2(IMG_W_MAX * IMG_H_MAX);
    localparam int DEPTH  = 2 ** (ADDR_W + 1); // Two blocks, block select on top.

    pixel_t mem [DEPTH];

    // Write port.
    always_ff @(posedge ice_img_clk16mhz) begin
        if (wr.wr_en) begin
            mem[{wr.wr_block, wr.wr_addr}] <= wr.wr_data;
        end
    end

    // Registered read, output holds between reads.
    always_ff @(posedge ice_img_clk16mhz) begin
        if (rd.rd_en) begin
            rd.rd_data <= mem[{rd.rd_block, rd.rd_addr}];
        end
    end

endmodule

`default_nettype wire

// File: src/img_pkg.sv
`default_nettype none

package img_pkg;

    typedef logic [11:0] pixel_t;    // One sensor sample.
    typedef logic [17:0] stat_cnt_t; // Highlight or shadow pixel count.

    // Exposure thresholds, inclusive at both ends.
    localparam pixel_t HIGHLIGHT_LEVEL = 12'hF00;
    localparam pixel_t SHADOW_LEVEL    = 12'h0FF;

    // Command opcodes.
    typedef enum logic {
        OP_CAPTURE = 1'b0,
        OP_READOUT = 1'b1
    } cmd_op_t;

    typedef enum logic [1:0] {
        CTRL_IDLE    = 2'd0, // Ready for a command.
        CTRL_ARM     = 2'd1, // Waiting for the next frame start.
        CTRL_CAPTURE = 2'd2,
        CTRL_READOUT = 2'd3
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: src/img_readout.sv
`timescale 1ns/1ps
`default_nettype none

module img_readout import img_pkg::*; #(
    parameter int IMG_W_MAX = 16,
    parameter int IMG_H_MAX = 8
) (
    input  logic                               ice_img_clk16mhz,
    input  logic                               arst_n,
    input  logic                               start,
    input  logic                               block,
    input  logic [$clog2(IMG_W_MAX + 1)-1:0]   width,
    input  logic [$clog2(IMG_H_MAX + 1)-1:0]   height,
    input  logic                               pix_ready,
    output logic                               done,
    output logic                               pix_valid,
    output pixel_t                             pix_data,
    output logic                               pix_last,
    mem_rd_if.src                              rd
);
    localparam int W_W    = $clog2(IMG_W_MAX + 1);
    localparam int H_W    = $clog2(IMG_H_MAX + 1);
    localparam int ADDR_W = $clog2(IMG_W_MAX * IMG_H_MAX);

    logic           running;     // Reads still to issue.
    logic [W_W-1:0] col;
    logic [H_W-1:0] row;
    logic           rd_pending;  // RAM data lands this cycle.
    logic           rd_last_q;
    logic           out_valid;
    logic           out_last;
    pixel_t         out_data;
    logic           skid_valid;
    logic           skid_last;
    pixel_t         skid_data;
    logic           empty_done;
    logic           empty;
    logic           pop;
    logic           out_free;
    logic           last_addr;
    logic           issue;
    logic [1:0]     level;
    logic           load_out_skid;
    logic           load_out_rd;
    logic           load_skid;

    assign empty     = (width == '0) || (height == '0);
    assign pop       = out_valid && pix_ready;
    assign out_free  = !out_valid || pop;
    assign last_addr = (col == width - 1'b1) && (row == height - 1'b1);

    // Issue only if output plus skid can take the data when it returns.
    assign level = {1'b0, out_valid} + {1'b0, skid_valid} + {1'b0, rd_pending} - {1'b0, pop};
    assign issue = running && !empty && (level <= 2'd1);

    assign load_out_skid = out_free && skid_valid;
    assign load_out_rd   = out_free && !skid_valid && rd_pending;
    assign load_skid     = rd_pending && (load_out_skid || !out_free);

    assign rd.rd_en    = issue;
    assign rd.rd_block = block;
    assign rd.rd_addr  = ADDR_W'(row * IMG_W_MAX + col);

    assign pix_valid = out_valid;
    assign pix_data  = out_data;
    assign pix_last  = out_last;
    assign done      = (pop && out_last) || empty_done;

    always_ff @(posedge ice_img_clk16mhz or negedge arst_n) begin
        if (!arst_n) begin
            running    <= 1'b0;
            col        <= '0;
            row        <= '0;
            rd_pending <= 1'b0;
            rd_last_q  <= 1'b0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            skid_valid <= 1'b0;
            empty_done <= 1'b0;
        end else begin
            rd_pending <= issue;
            rd_last_q  <= issue && last_addr;
            empty_done <= running && empty; // Zero-size frame, nothing to send.

            if (start) begin
                running <= 1'b1;
                col     <= '0;
                row     <= '0;
            end else if (issue) begin
                if (last_addr) running <= 1'b0;
                if (col == width - 1'b1) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end else if (running && empty) begin
                running <= 1'b0;
            end

            if (out_free) out_valid <= skid_valid || rd_pending;
            if (load_out_skid) out_last <= skid_last;
            else if (load_out_rd) out_last <= rd_last_q;

            if (load_skid) skid_valid <= 1'b1;
            else if (out_free) skid_valid <= 1'b0;
        end
    end

    always_ff @(posedge ice_img_clk16mhz) begin
        if (load_out_skid) out_data <= skid_data;
        else if (load_out_rd) out_data <= rd.rd_data;

        if (load_skid) begin
            skid_data <= rd.rd_data;
            skid_last <= rd_last_q;
        end
    end

    pix_hold: assert property (@(posedge ice_img_clk16mhz) disable iff (!arst_n)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_data))
        else $error("Stream beat changed while stalled.");

endmodule

`default_nettype wire

// File: src/img_sensor_rx.sv
`timescale 1ns/1ps
`default_nettype none

module img_sensor_rx import img_pkg::*; #(
    parameter int IMG_W_MAX = 16,
    parameter int IMG_H_MAX = 8
) (
    input  logic                               ice_img_clk16mhz,
    input  logic                               arst_n,
    input  logic                               start,
    input  logic                               block,
    input  pixel_t                             img_d,
    input  logic                               img_fv,
    input  logic                               img_lv,
    output logic                               frame_start,
    output logic                               frame_end,
    output logic [$clog2(IMG_W_MAX + 1)-1:0]   width,
    output logic [$clog2(IMG_H_MAX + 1)-1:0]   height,
    output stat_cnt_t                          highlight_count,
    output stat_cnt_t                          shadow_count,
    pix_wr_if.src                              wr
);
    localparam int W_W    = $clog2(IMG_W_MAX + 1);
    localparam int ADDR_W = $clog2(IMG_W_MAX * IMG_H_MAX);

    logic           fv_q;
    logic           lv_q;
    logic           armed;
    logic           capturing;
    logic [W_W-1:0] col;        // Stored pixels in the current line.
    logic           line_end;
    logic           take;

    assign frame_start = armed && img_fv && !fv_q;
    assign frame_end   = capturing && fv_q && !img_fv;
    assign line_end    = capturing && lv_q && !img_lv;

    // Clip anything outside the buffer window.
    assign take = (capturing || frame_start) && img_fv && img_lv &&
                  (col < IMG_W_MAX) && (height < IMG_H_MAX);

    always_ff @(posedge ice_img_clk16mhz or negedge arst_n) begin
        if (!arst_n) begin
            fv_q            <= 1'b0;
            lv_q            <= 1'b0;
            armed           <= 1'b0;
            capturing       <= 1'b0;
            col             <= '0;
            width           <= '0;
            height          <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
            wr.wr_en        <= 1'b0;
        end else begin
            fv_q     <= img_fv;
            lv_q     <= img_lv;
            wr.wr_en <= take;

            if (start) begin
                armed           <= 1'b1; // Ignore any frame already running.
                capturing       <= 1'b0;
                col             <= '0;
                width           <= '0;
                height          <= '0;
                highlight_count <= '0;
                shadow_count    <= '0;
            end else begin
                if (frame_start) begin
                    armed     <= 1'b0;
                    capturing <= 1'b1;
                end else if (frame_end) begin
                    capturing <= 1'b0;
                end

                if (line_end) begin
                    col <= '0;
                    if (height < IMG_H_MAX) begin
                        width  <= col;
                        height <= height + 1'b1;
                    end
                end else if (take) begin
                    col <= col + 1'b1;
                end

                if (take && img_d >= HIGHLIGHT_LEVEL) highlight_count <= highlight_count + 1'b1;
                if (take && img_d <= SHADOW_LEVEL) shadow_count <= shadow_count + 1'b1;
            end
        end
    end

    always_ff @(posedge ice_img_clk16mhz) begin
        wr.wr_block <= block;
        wr.wr_addr  <= ADDR_W'(height * IMG_W_MAX + col);
        wr.wr_data  <= img_d;
    end

    // Back-to-back writes belong to one line and land on neighbouring words.
    wr_addr_step: assert property (@(posedge ice_img_clk16mhz) disable iff (!arst_n)
        wr.wr_en && $past(wr.wr_en) |-> wr.wr_addr == $past(wr.wr_addr) + 1'b1)
        else $error("Pixel writes within a line are not consecutive.");

endmodule

`default_nettype wire

// File: src/img_top.sv
`timescale 1ns/1ps
`default_nettype none

module img_top import img_pkg::*; #(
    parameter int IMG_W_MAX = 16,
    parameter int IMG_H_MAX = 8
) (
    input  logic                               ice_img_clk16mhz,
    input  logic                               arst_n,
    // Command channel.
    input  logic                               cmd_valid,
    input  cmd_op_t                            cmd_op,
    input  logic                               cmd_block,
    output logic                               cmd_ready,
    // Sensor.
    input  pixel_t                             img_d,
    input  logic                               img_fv,
    input  logic                               img_lv,
    // Pixel stream.
    output logic                               pix_valid,
    output pixel_t                             pix_data,
    output logic                               pix_last,
    input  logic                               pix_ready,
    // Status.
    output logic                               capture_done,
    output logic [$clog2(IMG_W_MAX + 1)-1:0]   img_width,
    output logic [$clog2(IMG_H_MAX + 1)-1:0]   img_height,
    output stat_cnt_t                          highlight_count,
    output stat_cnt_t                          shadow_count
);

    img_controller #(.IMG_W_MAX(IMG_W_MAX), .IMG_H_MAX(IMG_H_MAX)) i_img_controller (
        .ice_img_clk16mhz (ice_img_clk16mhz),
        .arst_n           (arst_n),
        .cmd_valid        (cmd_valid),
        .cmd_op           (cmd_op),
        .cmd_block        (cmd_block),
        .cmd_ready        (cmd_ready),
        .img_d            (img_d),
        .img_fv           (img_fv),
        .img_lv           (img_lv),
        .capture_done     (capture_done),
        .img_width        (img_width),
        .img_height       (img_height),
        .highlight_count  (highlight_count),
        .shadow_count     (shadow_count),
        .pix_ready        (pix_ready),
        .pix_valid        (pix_valid),
        .pix_data         (pix_data),
        .pix_last         (pix_last)
    );

endmodule

`default_nettype wire

// File: src/mem_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_rd_if import img_pkg::*; #(
    parameter int IMG_W_MAX = 16,
    parameter int IMG_H_MAX = 8
);
    localparam int ADDR_W = $clog2(IMG_W_MAX * IMG_H_MAX);

    logic              rd_en;
    logic              rd_block;
    logic [ADDR_W-1:0] rd_addr;
    pixel_t            rd_data;  // Valid one cycle after rd_en, held until the next read.

    modport src (output rd_en, rd_block, rd_addr, input rd_data);
    modport dst (input rd_en, rd_block, rd_addr, output rd_data);

endinterface

`default_nettype wire

// File: src/pix_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pix_wr_if import img_pkg::*; #(
    parameter int IMG_W_MAX = 16,
    parameter int IMG_H_MAX = 8
);
    localparam int ADDR_W = $clog2(IMG_W_MAX * IMG_H_MAX);

    logic              wr_en;
    logic              wr_block;
    logic [ADDR_W-1:0] wr_addr;  // Line * IMG_W_MAX + column.
    pixel_t            wr_data;

    modport src (output wr_en, wr_block, wr_addr, wr_data);
    modport dst (input wr_en, wr_block, wr_addr, wr_data);

endinterface

`default_nettype wire

// File: test/img_tb_tasks.svh
`ifndef IMG_TB_TASKS_SVH
`define IMG_TB_TASKS_SVH

// Value compares, one per kind of result.
task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp) begin
        $display("MISMATCH %s: got 0x%03h, expected 0x%03h at %0t", name, got, exp, $time);
        error_count++;
    end
endtask

task automatic check_count(input string name, input stat_cnt_t got, input stat_cnt_t exp);
    if (got !== exp) begin
        $display("MISMATCH %s: got 0x%05h, expected 0x%05h at %0t", name, got, exp, $time);
        error_count++;
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        error_count++;
    end
endtask

task automatic check_op_done(input bit ok, input string what);
    if (!ok) begin
        $display("Sequencing error at %0t: %s.", $time, what);
        error_count++;
    end
endtask

// Random samples with a few fixed threshold cases planted.
task automatic fill_frame(input int w, input int h, input int base);
    for (int i = 0; i < w * h; i++) begin
        stim_pix[base + i] = pixel_t'($urandom);
    end
    stim_pix[base + 0]         = 12'hFFF;
    stim_pix[base + 1]         = 12'hF00;
    stim_pix[base + 2]         = 12'h0FF;
    stim_pix[base + 3]         = 12'h000;
    stim_pix[base + w + 4]     = 12'hEFF; // Just under highlight.
    stim_pix[base + w + 5]     = 12'h100; // Just over shadow.
    stim_pix[base + w * h - 1] = 12'hF80;
endtask

// One frame: blanking, lines of w pixels separated by gap idle cycles.
task automatic drive_frame(input int w, input int h, input int base, input int gap);
    @(negedge ice_img_clk16mhz);
    img_fv = 1'b0;
    img_lv = 1'b0;
    repeat (FRONT_BLANK) @(negedge ice_img_clk16mhz);
    img_fv = 1'b1;
    repeat (2) @(negedge ice_img_clk16mhz);
    for (int r = 0; r < h; r++) begin
        for (int c = 0; c < w; c++) begin
            img_lv = 1'b1;
            img_d  = stim_pix[base + r * w + c];
            @(negedge ice_img_clk16mhz);
        end
        img_lv = 1'b0;
        img_d  = '0;
        repeat (gap) @(negedge ice_img_clk16mhz);
    end
    img_fv = 1'b0;
endtask

task automatic send_cmd(input cmd_op_t op, input logic blk);
    int n;
    bit taken;
    @(negedge ice_img_clk16mhz);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_block = blk;
    n = 0;
    while (!cmd_ready && n < 50) begin
        @(negedge ice_img_clk16mhz);
        n++;
    end
    taken = cmd_ready;
    @(negedge ice_img_clk16mhz); // Transfer on the rising edge in between.
    cmd_valid = 1'b0;
    check_op_done(taken, "command was not accepted before the timeout");
endtask

task automatic wait_ready(input int limit, input string msg);
    int n;
    n = 0;
    while (!cmd_ready && n < limit) begin
        @(negedge ice_img_clk16mhz);
        n++;
    end
    check_op_done(cmd_ready, msg);
endtask

// Returns on the cycle that shows the done pulse.
task automatic wait_capture(input int limit);
    int n;
    bit early;
    n = 0;
    early = 0;
    do begin
        @(negedge ice_img_clk16mhz);
        n++;
        if (!capture_done && cmd_ready) early = 1;
    end while (!capture_done && n < limit);
    check_op_done(capture_done, "capture_done did not pulse before the timeout");
    check_op_done(!early, "cmd_ready rose before capture_done");
    check_flag("cmd_ready", cmd_ready, 1'b1);
endtask

task automatic check_status(input int blk);
    check_count("img_width", stat_cnt_t'(img_width), stat_cnt_t'(model_w[blk]));
    check_count("img_height", stat_cnt_t'(img_height), stat_cnt_t'(model_h[blk]));
    check_count("highlight_count", highlight_count, exp_highlight);
    check_count("shadow_count", shadow_count, exp_shadow);
endtask

// Takes beats in row order, random stalls when gaps is set.
task automatic collect_stream(input int blk, input bit gaps);
    int n_exp;
    int beats;
    int cycles;
    int idx;
    n_exp  = model_w[blk] * model_h[blk];
    beats  = 0;
    cycles = 0;
    while (beats < n_exp && cycles < 4 * n_exp + 20) begin
        pix_ready = gaps ? ($urandom % 3 != 0) : 1'b1;
        if (pix_valid && pix_ready) begin
            idx = (beats / model_w[blk]) * IMG_W_MAX + beats % model_w[blk];
            check_pixel("pix_data", pix_data, model_mem[blk][idx]);
            check_flag("pix_last", pix_last, beats == n_exp - 1);
            if (!gaps) check_op_done(cycles == beats + 2, "stream beat arrived off its cycle");
            beats++;
        end
        @(negedge ice_img_clk16mhz);
        cycles++;
    end
    check_op_done(beats == n_exp, "stream stopped before all pixels arrived");
    check_flag("pix_valid", pix_valid, 1'b0);
    wait_ready(4, "cmd_ready did not return after the last beat");
    pix_ready = 1'b1;
endtask

`endif

// File: test/img_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module img_top_tb import img_pkg::*; ();

    localparam int IMG_W_MAX   = 16;
    localparam int IMG_H_MAX   = 8;
    localparam int W_W         = $clog2(IMG_W_MAX + 1);
    localparam int H_W         = $clog2(IMG_H_MAX + 1);
    localparam int BLK_WORDS   = IMG_W_MAX * IMG_H_MAX;
    localparam int MAX_STIM    = 512;
    localparam int FRONT_BLANK = 6;
    localparam pixel_t HIGHLIGHT_MIN = 12'hF00;
    localparam pixel_t SHADOW_MAX    = 12'h0FF;

    logic           ice_img_clk16mhz;
    logic           arst_n;
    logic           cmd_valid;
    cmd_op_t        cmd_op;
    logic           cmd_block;
    logic           cmd_ready;
    pixel_t         img_d;
    logic           img_fv;
    logic           img_lv;
    logic           pix_valid;
    pixel_t         pix_data;
    logic           pix_last;
    logic           pix_ready;
    logic           capture_done;
    logic [W_W-1:0] img_width;
    logic [H_W-1:0] img_height;
    stat_cnt_t      highlight_count;
    stat_cnt_t      shadow_count;

    pixel_t    stim_pix [MAX_STIM];
    pixel_t    model_mem [2][BLK_WORDS]; // Expected contents of each block.
    int        model_w [2];
    int        model_h [2];
    stat_cnt_t exp_highlight;
    stat_cnt_t exp_shadow;
    int        error_count;
    int        test_count;
    int        failed_tests;
    int        test_err_base;
    string     test_name;

    img_top #(.IMG_W_MAX(IMG_W_MAX), .IMG_H_MAX(IMG_H_MAX)) i_img_top (
        .ice_img_clk16mhz (ice_img_clk16mhz),
        .arst_n           (arst_n),
        .cmd_valid        (cmd_valid),
        .cmd_op           (cmd_op),
        .cmd_block        (cmd_block),
        .cmd_ready        (cmd_ready),
        .img_d            (img_d),
        .img_fv           (img_fv),
        .img_lv           (img_lv),
        .pix_valid        (pix_valid),
        .pix_data         (pix_data),
        .pix_last         (pix_last),
        .pix_ready        (pix_ready),
        .capture_done     (capture_done),
        .img_width        (img_width),
        .img_height       (img_height),
        .highlight_count  (highlight_count),
        .shadow_count     (shadow_count)
    );

    `include "img_tb_tasks.svh"

    // Stored size follows the buffer window.
    task automatic record_frame(input int blk, input int w, input int h, input int base);
        int sw;
        int sh;
        pixel_t p;
        sw = (w < IMG_W_MAX) ? w : IMG_W_MAX;
        sh = (h < IMG_H_MAX) ? h : IMG_H_MAX;
        model_w[blk]  = sw;
        model_h[blk]  = sh;
        exp_highlight = '0;
        exp_shadow    = '0;
        for (int r = 0; r < sh; r++) begin
            for (int c = 0; c < sw; c++) begin
                p = stim_pix[base + r * w + c];
                model_mem[blk][r * IMG_W_MAX + c] = p;
                if (p >= HIGHLIGHT_MIN) exp_highlight++;
                if (p <= SHADOW_MAX) exp_shadow++;
            end
        end
    endtask

    function automatic int frame_cycles(input int w, input int h, input int gap);
        return FRONT_BLANK + 3 + h * (w + gap);
    endfunction

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = error_count;
    endtask

    task automatic end_test();
        test_count++;
        if (error_count == test_err_base) begin
            $display("Test %0d %s: passed", test_count, test_name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: failed with %0d errors", test_count, test_name,
                     error_count - test_err_base);
        end
    endtask

    task automatic test_reset_state();
        start_test("reset state");
        @(negedge ice_img_clk16mhz);
        check_flag("cmd_ready", cmd_ready, 1'b1);
        check_flag("pix_valid", pix_valid, 1'b0);
        check_flag("capture_done", capture_done, 1'b0);
        end_test();
    endtask

    task automatic test_full_frame();
        start_test("full frame into block 0");
        fill_frame(16, 8, 0);
        record_frame(0, 16, 8, 0);
        send_cmd(OP_CAPTURE, 1'b0);
        drive_frame(16, 8, 0, 4);
        wait_capture(8);
        check_status(0);
        send_cmd(OP_READOUT, 1'b0);
        collect_stream(0, 1'b0);
        end_test();
    endtask

    task automatic test_oversize_stall();
        start_test("clipped frame into block 1 with back-pressure");
        fill_frame(20, 10, 0);
        record_frame(1, 20, 10, 0);
        send_cmd(OP_CAPTURE, 1'b1);
        drive_frame(20, 10, 0, 2);
        wait_capture(8);
        check_status(1);
        send_cmd(OP_READOUT, 1'b1);
        collect_stream(1, 1'b1);
        end_test();
    endtask

    // Command lands in the middle of the first frame.
    task automatic test_arm_waits();
        start_test("arm waits for frame start");
        fill_frame(16, 8, 0);
        fill_frame(16, 8, 256);
        record_frame(0, 16, 8, 256);
        fork
            begin
                drive_frame(16, 8, 0, 4);
                drive_frame(16, 8, 256, 4);
            end
            begin
                repeat (30) @(negedge ice_img_clk16mhz);
                send_cmd(OP_CAPTURE, 1'b0);
                wait_capture(400);
            end
        join
        check_status(0);
        send_cmd(OP_READOUT, 1'b0);
        collect_stream(0, 1'b0);
        end_test();
    endtask

    // Block 0 gets a smaller frame so block 1 must keep its own size.
    task automatic test_blocks_apart();
        start_test("blocks are independent");
        fill_frame(12, 6, 0);
        record_frame(0, 12, 6, 0);
        send_cmd(OP_CAPTURE, 1'b0);
        drive_frame(12, 6, 0, 4);
        wait_capture(8);
        check_status(0);
        send_cmd(OP_READOUT, 1'b1);
        collect_stream(1, 1'b0);
        end_test();
    endtask

    initial begin
        ice_img_clk16mhz = 1'b0;
        forever #20 ice_img_clk16mhz = ~ice_img_clk16mhz;
    end

    initial begin : watchdog
        int limit;
        limit = 4 * (3 * frame_cycles(16, 8, 4) + frame_cycles(20, 10, 2) +
                     frame_cycles(12, 6, 4)) + 2000;
        repeat (limit) @(posedge ice_img_clk16mhz);
        $display("Watchdog expired after %0d cycles, the run is stuck.", limit);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(12));
        arst_n        = 1'b0;
        cmd_valid     = 1'b0;
        cmd_op        = OP_CAPTURE;
        cmd_block     = 1'b0;
        img_d         = '0;
        img_fv        = 1'b0;
        img_lv        = 1'b0;
        pix_ready     = 1'b1;
        error_count   = 0;
        test_count    = 0;
        failed_tests  = 0;
        test_err_base = 0;
        repeat (8) @(negedge ice_img_clk16mhz);
        arst_n = 1'b1;

        test_reset_state();
        test_full_frame();
        test_oversize_stall();
        test_arm_waits();
        test_blocks_apart();

        $display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
